/* rtl/front_defs.svh */
// Front end widths and reset values shared by the fetch, decode and rename stages
`ifndef FRONT_DEFS_SVH
`define FRONT_DEFS_SVH

// Data and address width
`define XLEN 32

// Physical tag width that wraps after 64 allocations
`define TAG_BITS 6

// Architectural register file size
`define ARCH_REGS 32

// First pair fetched after reset on an 8-byte boundary
`define RESET_PC 32'h0000_0000

`endif

/* rtl/front_pkg.sv */
// Front end package with operation class and control state types
`default_nettype none

package front_pkg;

  // Operation class from the major opcode
  typedef enum logic [3:0] {
    OP_ALU_REG  = 4'd0,
    OP_ALU_IMM  = 4'd1,
    OP_LOAD     = 4'd2,
    OP_STORE    = 4'd3,
    OP_BRANCH   = 4'd4,
    OP_JAL      = 4'd5,
    OP_JALR     = 4'd6,
    OP_LUI      = 4'd7,
    OP_AUIPC    = 4'd8,
    OP_INVALID  = 4'd15
  } op_kind_e;

  // Front end control states
  typedef enum logic [1:0] {
    CTRL_RUN   = 2'd0,
    CTRL_STALL = 2'd1,
    CTRL_FLUSH = 2'd2
  } ctrl_state_e;

endpackage

`default_nettype wire

/* rtl/fetch_loader.sv */
// Fetch loader keeping the pair program counter and the fetch pair register
`timescale 1ns/1ps
`default_nettype none

`include "front_defs.svh"

module fetch_loader (
  input  wire              i_clock,
  input  wire              i_reset,
  input  wire              i_fetch_hit,
  input  wire [`XLEN-1:0]  i_fetch_instr_0,
  input  wire [`XLEN-1:0]  i_fetch_instr_1,
  input  wire              i_jump_valid,
  input  wire [`XLEN-1:0]  i_jump_address,
  input  wire              i_enable,
  input  wire              i_flush,
  output logic             o_fetch_read,
  output logic [`XLEN-1:0] o_fetch_address,
  output logic             o_pair_valid,
  output logic [`XLEN-1:0] o_pair_address,
  output logic [`XLEN-1:0] o_instr_0,
  output logic [`XLEN-1:0] o_instr_1
);

  logic [`XLEN-1:0] pc;
  logic             started;
  logic             redirect_pending;
  logic [`XLEN-1:0] redirect_address;
  logic             load_pair;

  // No request in the first cycle after reset, during flush,
  // or while a full fetch register cannot move on
  assign o_fetch_read    = started && !i_flush && (!o_pair_valid || i_enable);
  assign o_fetch_address = pc;
  assign load_pair       = o_fetch_read && i_fetch_hit;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      started          <= 1'b0;
      pc               <= `RESET_PC;
      o_pair_valid     <= 1'b0;
      redirect_pending <= 1'b0;
    end else begin
      started <= 1'b1;

      // A new jump wins over the one consumed by this flush
      if (i_jump_valid) begin
        redirect_pending <= 1'b1;
      end else if (i_flush) begin
        redirect_pending <= 1'b0;
      end

      if (i_flush) begin
        o_pair_valid <= 1'b0;
        if (redirect_pending) begin
          pc <= redirect_address;
        end
      end else begin
        if (i_enable) begin
          o_pair_valid <= load_pair;
        end
        if (load_pair) begin
          pc <= pc + `XLEN'(8);
        end
      end
    end
  end

  // Redirect target and fetched words
  always_ff @(posedge i_clock) begin
    if (i_jump_valid) begin
      redirect_address <= i_jump_address;
    end
    if (load_pair && !i_flush) begin
      o_pair_address <= pc;
      o_instr_0      <= i_fetch_instr_0;
      o_instr_1      <= i_fetch_instr_1;
    end
  end

endmodule

`default_nettype wire

/* rtl/instr_decoder.sv */
// Single-word RV32I decoder with registered class, register fields and immediate
`timescale 1ns/1ps
`default_nettype none

`include "front_defs.svh"

module instr_decoder import front_pkg::*; #(
  parameter int REG_BITS = $clog2(`ARCH_REGS)
) (
  input  wire                 i_clock,
  input  wire                 i_reset,
  input  wire                 i_enable,
  input  wire                 i_flush,
  input  wire                 i_valid,
  input  wire [`XLEN-1:0]     i_instr,
  output logic                o_valid,
  output op_kind_e            o_op,
  output logic [REG_BITS-1:0] o_rd,
  output logic [REG_BITS-1:0] o_rs1,
  output logic [REG_BITS-1:0] o_rs2,
  output logic [`XLEN-1:0]    o_imm,
  output logic                o_writes_rd
);

  op_kind_e            op;
  logic [`XLEN-1:0]    imm;
  logic                uses_rs1;
  logic                uses_rs2;
  logic                class_writes;
  logic                writes_rd;
  logic [REG_BITS-1:0] rd_field;

  assign rd_field  = i_instr[11:7];
  assign writes_rd = class_writes && (rd_field != '0);

  always_comb begin
    op           = OP_INVALID;
    imm          = '0;
    uses_rs1     = 1'b0;
    uses_rs2     = 1'b0;
    class_writes = 1'b0;
    case (i_instr[6:0])
      7'b0110011: begin
        op           = OP_ALU_REG;
        uses_rs1     = 1'b1;
        uses_rs2     = 1'b1;
        class_writes = 1'b1;
      end
      7'b0010011: begin
        op           = OP_ALU_IMM;
        imm          = {{20{i_instr[31]}}, i_instr[31:20]};
        uses_rs1     = 1'b1;
        class_writes = 1'b1;
      end
      7'b0000011: begin
        op           = OP_LOAD;
        imm          = {{20{i_instr[31]}}, i_instr[31:20]};
        uses_rs1     = 1'b1;
        class_writes = 1'b1;
      end
      7'b0100011: begin
        op       = OP_STORE;
        imm      = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      7'b1100011: begin
        op       = OP_BRANCH;
        imm      = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      7'b1101111: begin
        op           = OP_JAL;
        imm          = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                        i_instr[30:21], 1'b0};
        class_writes = 1'b1;
      end
      7'b1100111: begin
        op           = OP_JALR;
        imm          = {{20{i_instr[31]}}, i_instr[31:20]};
        uses_rs1     = 1'b1;
        class_writes = 1'b1;
      end
      7'b0110111: begin
        op           = OP_LUI;
        imm          = {i_instr[31:12], 12'b0};
        class_writes = 1'b1;
      end
      7'b0010111: begin
        op           = OP_AUIPC;
        imm          = {i_instr[31:12], 12'b0};
        class_writes = 1'b1;
      end
      default: begin
        op = OP_INVALID;
      end
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (i_reset || i_flush) begin
      o_valid <= 1'b0;
    end else if (i_enable) begin
      o_valid <= i_valid;
    end
  end

  // Unused register fields read as x0 so the renamer sees no dependency
  always_ff @(posedge i_clock) begin
    if (i_enable) begin
      o_op        <= op;
      o_imm       <= imm;
      o_rd        <= writes_rd ? rd_field : '0;
      o_rs1       <= uses_rs1 ? i_instr[19:15] : '0;
      o_rs2       <= uses_rs2 ? i_instr[24:20] : '0;
      o_writes_rd <= writes_rd;
    end
  end

endmodule

`default_nettype wire

/* rtl/reg_renamer.sv */
// Register renamer with rename table, tag counter, pair bypass and issue register
`timescale 1ns/1ps
`default_nettype none

`include "front_defs.svh"

module reg_renamer import front_pkg::*; #(
  parameter int REG_BITS = $clog2(`ARCH_REGS)
) (
  input  wire                  i_clock,
  input  wire                  i_reset,
  input  wire                  i_enable,
  input  wire                  i_valid,
  input  wire [`XLEN-1:0]      i_address,
  input  op_kind_e             i_slot0_op,
  input  wire [REG_BITS-1:0]   i_slot0_rd,
  input  wire [REG_BITS-1:0]   i_slot0_rs1,
  input  wire [REG_BITS-1:0]   i_slot0_rs2,
  input  wire [`XLEN-1:0]      i_slot0_imm,
  input  wire                  i_slot0_writes_rd,
  input  op_kind_e             i_slot1_op,
  input  wire [REG_BITS-1:0]   i_slot1_rd,
  input  wire [REG_BITS-1:0]   i_slot1_rs1,
  input  wire [REG_BITS-1:0]   i_slot1_rs2,
  input  wire [`XLEN-1:0]      i_slot1_imm,
  input  wire                  i_slot1_writes_rd,
  output logic                 o_issue_valid,
  output logic [`XLEN-1:0]     o_issue_address,
  output op_kind_e             o_slot0_op,
  output logic [`XLEN-1:0]     o_slot0_imm,
  output logic [`TAG_BITS-1:0] o_slot0_dst_tag,
  output logic [`TAG_BITS-1:0] o_slot0_src1_tag,
  output logic                 o_slot0_src1_pending,
  output logic [`TAG_BITS-1:0] o_slot0_src2_tag,
  output logic                 o_slot0_src2_pending,
  output op_kind_e             o_slot1_op,
  output logic [`XLEN-1:0]     o_slot1_imm,
  output logic [`TAG_BITS-1:0] o_slot1_dst_tag,
  output logic [`TAG_BITS-1:0] o_slot1_src1_tag,
  output logic                 o_slot1_src1_pending,
  output logic [`TAG_BITS-1:0] o_slot1_src2_tag,
  output logic                 o_slot1_src2_pending
);

  logic [`TAG_BITS-1:0] table_tag [`ARCH_REGS];
  logic [`ARCH_REGS-1:0] table_pending;
  logic [`TAG_BITS-1:0] next_tag;
  logic [`TAG_BITS-1:0] tag_0;
  logic [`TAG_BITS-1:0] tag_1;
  logic                 rename_fire;

  logic [`TAG_BITS-1:0] s0_src1_tag, s0_src2_tag, s1_src1_tag, s1_src2_tag;
  logic                 s0_src1_pending, s0_src2_pending, s1_src1_pending, s1_src2_pending;

  // Slot 1 takes the tag after slot 0's only if slot 0 allocated one
  assign tag_0       = next_tag;
  assign tag_1       = next_tag + `TAG_BITS'(i_slot0_writes_rd);
  assign rename_fire = i_enable && i_valid;

  // x0 never pending and tag zero when not pending
  always_comb begin
    s0_src1_pending = (i_slot0_rs1 != '0) && table_pending[i_slot0_rs1];
    s0_src1_tag     = s0_src1_pending ? table_tag[i_slot0_rs1] : '0;
    s0_src2_pending = (i_slot0_rs2 != '0) && table_pending[i_slot0_rs2];
    s0_src2_tag     = s0_src2_pending ? table_tag[i_slot0_rs2] : '0;
    s1_src1_pending = (i_slot1_rs1 != '0) && table_pending[i_slot1_rs1];
    s1_src1_tag     = s1_src1_pending ? table_tag[i_slot1_rs1] : '0;
    s1_src2_pending = (i_slot1_rs2 != '0) && table_pending[i_slot1_rs2];
    s1_src2_tag     = s1_src2_pending ? table_tag[i_slot1_rs2] : '0;

    // Slot 1 reading slot 0's destination
    if (i_slot0_writes_rd && (i_slot1_rs1 == i_slot0_rd)) begin
      s1_src1_pending = 1'b1;
      s1_src1_tag     = tag_0;
    end
    if (i_slot0_writes_rd && (i_slot1_rs2 == i_slot0_rd)) begin
      s1_src2_pending = 1'b1;
      s1_src2_tag     = tag_0;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      table_pending <= '0;
      next_tag      <= '0;
      o_issue_valid <= 1'b0;
    end else begin
      if (i_enable) begin
        o_issue_valid <= i_valid;
      end
      if (rename_fire) begin
        next_tag <= tag_1 + `TAG_BITS'(i_slot1_writes_rd);
        if (i_slot0_writes_rd) begin
          table_pending[i_slot0_rd] <= 1'b1;
        end
        if (i_slot1_writes_rd) begin
          table_pending[i_slot1_rd] <= 1'b1;
        end
      end
    end
  end

  // Slot 1 written last so it owns a shared rd
  always_ff @(posedge i_clock) begin
    if (rename_fire) begin
      if (i_slot0_writes_rd) begin
        table_tag[i_slot0_rd] <= tag_0;
      end
      if (i_slot1_writes_rd) begin
        table_tag[i_slot1_rd] <= tag_1;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_enable) begin
      o_issue_address      <= i_address;
      o_slot0_op           <= i_slot0_op;
      o_slot0_imm          <= i_slot0_imm;
      o_slot0_dst_tag      <= i_slot0_writes_rd ? tag_0 : '0;
      o_slot0_src1_tag     <= s0_src1_tag;
      o_slot0_src1_pending <= s0_src1_pending;
      o_slot0_src2_tag     <= s0_src2_tag;
      o_slot0_src2_pending <= s0_src2_pending;
      o_slot1_op           <= i_slot1_op;
      o_slot1_imm          <= i_slot1_imm;
      o_slot1_dst_tag      <= i_slot1_writes_rd ? tag_1 : '0;
      o_slot1_src1_tag     <= s1_src1_tag;
      o_slot1_src1_pending <= s1_src1_pending;
      o_slot1_src2_tag     <= s1_src2_tag;
      o_slot1_src2_pending <= s1_src2_pending;
    end
  end

endmodule

`default_nettype wire

/* rtl/front_control.sv */
// Front end control FSM producing stage enables and the jump flush
`timescale 1ns/1ps
`default_nettype none

module front_control import front_pkg::*; (
  input  wire  i_clock,
  input  wire  i_reset,
  input  wire  i_jump_valid,
  input  wire  i_fetch_valid,
  input  wire  i_decode_valid,
  input  wire  i_issue_valid,
  input  wire  i_issue_ready,
  output logic o_fetch_enable,
  output logic o_decode_enable,
  output logic o_rename_enable,
  output logic o_flush
);

  ctrl_state_e state;
  ctrl_state_e state_next;

  // Jump takes priority over back-pressure
  always_comb begin
    if (i_jump_valid) begin
      state_next = CTRL_FLUSH;
    end else if (i_issue_valid && !i_issue_ready) begin
      state_next = CTRL_STALL;
    end else begin
      state_next = CTRL_RUN;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      state <= CTRL_RUN;
    end else begin
      state <= state_next;
    end
  end

  // A stage loads when the next one is empty or loading too
  assign o_rename_enable = !i_issue_valid || i_issue_ready;
  assign o_decode_enable = !i_decode_valid || o_rename_enable;
  assign o_fetch_enable  = !i_fetch_valid || o_decode_enable;
  assign o_flush         = (state == CTRL_FLUSH);

endmodule

`default_nettype wire

/* rtl/instr_front_end.sv */
// Dual-issue front end top joining fetch, two decoders, renamer and control
`timescale 1ns/1ps
`default_nettype none

`include "front_defs.svh"

module instr_front_end import front_pkg::*; (
  input  wire                  i_clock,
  input  wire                  i_reset,
  output logic                 o_fetch_read,
  output logic [`XLEN-1:0]     o_fetch_address,
  input  wire                  i_fetch_hit,
  input  wire [`XLEN-1:0]      i_fetch_instr_0,
  input  wire [`XLEN-1:0]      i_fetch_instr_1,
  input  wire                  i_jump_valid,
  input  wire [`XLEN-1:0]      i_jump_address,
  input  wire                  i_issue_ready,
  output logic                 o_issue_valid,
  output logic [`XLEN-1:0]     o_issue_address,
  output op_kind_e             o_slot0_op,
  output logic [`XLEN-1:0]     o_slot0_imm,
  output logic [`TAG_BITS-1:0] o_slot0_dst_tag,
  output logic [`TAG_BITS-1:0] o_slot0_src1_tag,
  output logic                 o_slot0_src1_pending,
  output logic [`TAG_BITS-1:0] o_slot0_src2_tag,
  output logic                 o_slot0_src2_pending,
  output op_kind_e             o_slot1_op,
  output logic [`XLEN-1:0]     o_slot1_imm,
  output logic [`TAG_BITS-1:0] o_slot1_dst_tag,
  output logic [`TAG_BITS-1:0] o_slot1_src1_tag,
  output logic                 o_slot1_src1_pending,
  output logic [`TAG_BITS-1:0] o_slot1_src2_tag,
  output logic                 o_slot1_src2_pending
);

  localparam int REG_BITS = $clog2(`ARCH_REGS);

  logic fetch_enable, decode_enable, rename_enable, flush;
  logic pair_valid, decode_valid, decode_valid_0, decode_valid_1, rename_valid;
  logic [`XLEN-1:0] pair_address, decode_address, instr_0, instr_1;

  op_kind_e            op_0, op_1;
  logic [REG_BITS-1:0] rd_0, rs1_0, rs2_0, rd_1, rs1_1, rs2_1;
  logic [`XLEN-1:0]    imm_0, imm_1;
  logic                writes_rd_0, writes_rd_1;

  assign decode_valid = decode_valid_0 && decode_valid_1;

  // Keep younger pairs out of the issue register on the jump and flush cycles
  assign rename_valid = decode_valid && !i_jump_valid && !flush;

  // Pair address follows the words through decode
  always_ff @(posedge i_clock) begin
    if (decode_enable) begin
      decode_address <= pair_address;
    end
  end

  fetch_loader u_loader (
    .i_clock(i_clock), .i_reset(i_reset),
    .i_fetch_hit(i_fetch_hit),
    .i_fetch_instr_0(i_fetch_instr_0), .i_fetch_instr_1(i_fetch_instr_1),
    .i_jump_valid(i_jump_valid), .i_jump_address(i_jump_address),
    .i_enable(fetch_enable), .i_flush(flush),
    .o_fetch_read(o_fetch_read), .o_fetch_address(o_fetch_address),
    .o_pair_valid(pair_valid), .o_pair_address(pair_address),
    .o_instr_0(instr_0), .o_instr_1(instr_1)
  );

  instr_decoder u_decoder_0 (
    .i_clock(i_clock), .i_reset(i_reset),
    .i_enable(decode_enable), .i_flush(flush),
    .i_valid(pair_valid), .i_instr(instr_0),
    .o_valid(decode_valid_0), .o_op(op_0),
    .o_rd(rd_0), .o_rs1(rs1_0), .o_rs2(rs2_0),
    .o_imm(imm_0), .o_writes_rd(writes_rd_0)
  );

  instr_decoder u_decoder_1 (
    .i_clock(i_clock), .i_reset(i_reset),
    .i_enable(decode_enable), .i_flush(flush),
    .i_valid(pair_valid), .i_instr(instr_1),
    .o_valid(decode_valid_1), .o_op(op_1),
    .o_rd(rd_1), .o_rs1(rs1_1), .o_rs2(rs2_1),
    .o_imm(imm_1), .o_writes_rd(writes_rd_1)
  );

  reg_renamer u_renamer (
    .i_clock(i_clock), .i_reset(i_reset),
    .i_enable(rename_enable), .i_valid(rename_valid), .i_address(decode_address),
    .i_slot0_op(op_0), .i_slot0_rd(rd_0), .i_slot0_rs1(rs1_0), .i_slot0_rs2(rs2_0),
    .i_slot0_imm(imm_0), .i_slot0_writes_rd(writes_rd_0),
    .i_slot1_op(op_1), .i_slot1_rd(rd_1), .i_slot1_rs1(rs1_1), .i_slot1_rs2(rs2_1),
    .i_slot1_imm(imm_1), .i_slot1_writes_rd(writes_rd_1),
    .o_issue_valid(o_issue_valid), .o_issue_address(o_issue_address),
    .o_slot0_op(o_slot0_op), .o_slot0_imm(o_slot0_imm),
    .o_slot0_dst_tag(o_slot0_dst_tag),
    .o_slot0_src1_tag(o_slot0_src1_tag), .o_slot0_src1_pending(o_slot0_src1_pending),
    .o_slot0_src2_tag(o_slot0_src2_tag), .o_slot0_src2_pending(o_slot0_src2_pending),
    .o_slot1_op(o_slot1_op), .o_slot1_imm(o_slot1_imm),
    .o_slot1_dst_tag(o_slot1_dst_tag),
    .o_slot1_src1_tag(o_slot1_src1_tag), .o_slot1_src1_pending(o_slot1_src1_pending),
    .o_slot1_src2_tag(o_slot1_src2_tag), .o_slot1_src2_pending(o_slot1_src2_pending)
  );

  front_control u_control (
    .i_clock(i_clock), .i_reset(i_reset),
    .i_jump_valid(i_jump_valid),
    .i_fetch_valid(pair_valid), .i_decode_valid(decode_valid),
    .i_issue_valid(o_issue_valid), .i_issue_ready(i_issue_ready),
    .o_fetch_enable(fetch_enable), .o_decode_enable(decode_enable),
    .o_rename_enable(rename_enable), .o_flush(flush)
  );

endmodule

`default_nettype wire

/* test/front_end_props.sv */
// Front end issue port assertions for back-pressure stability and reset state
`timescale 1ns/1ps
`default_nettype none

`include "front_defs.svh"

module front_end_props import front_pkg::*; (
  input wire                  i_clock,
  input wire                  i_reset,
  input wire                  i_fetch_read,
  input wire                  i_issue_ready,
  input wire                  i_issue_valid,
  input wire [`XLEN-1:0]      i_issue_address,
  input op_kind_e             i_slot0_op,
  input wire [`XLEN-1:0]      i_slot0_imm,
  input wire [`TAG_BITS-1:0]  i_slot0_dst_tag,
  input op_kind_e             i_slot1_op,
  input wire [`XLEN-1:0]      i_slot1_imm,
  input wire [`TAG_BITS-1:0]  i_slot1_dst_tag
);

  // A held pair keeps valid and address
  held_address: assert property (@(posedge i_clock) disable iff (i_reset)
    (i_issue_valid && !i_issue_ready) |=> (i_issue_valid && $stable(i_issue_address)))
    else $error("issue address or valid changed while the port was held");

  held_slot0: assert property (@(posedge i_clock) disable iff (i_reset)
    (i_issue_valid && !i_issue_ready) |=> $stable({i_slot0_op, i_slot0_imm, i_slot0_dst_tag}))
    else $error("slot 0 payload changed while the port was held");

  held_slot1: assert property (@(posedge i_clock) disable iff (i_reset)
    (i_issue_valid && !i_issue_ready) |=> $stable({i_slot1_op, i_slot1_imm, i_slot1_dst_tag}))
    else $error("slot 1 payload changed while the port was held");

  quiet_in_reset: assert property (@(posedge i_clock)
    i_reset |=> (!i_issue_valid && !i_fetch_read))
    else $error("fetch read or issue valid high during reset");

endmodule

bind instr_front_end front_end_props u_props (
  .i_clock(i_clock),
  .i_reset(i_reset),
  .i_fetch_read(o_fetch_read),
  .i_issue_ready(i_issue_ready),
  .i_issue_valid(o_issue_valid),
  .i_issue_address(o_issue_address),
  .i_slot0_op(o_slot0_op),
  .i_slot0_imm(o_slot0_imm),
  .i_slot0_dst_tag(o_slot0_dst_tag),
  .i_slot1_op(o_slot1_op),
  .i_slot1_imm(o_slot1_imm),
  .i_slot1_dst_tag(o_slot1_dst_tag)
);

`default_nettype wire

/* test/tb_front_end.sv */
// Front end testbench with memory model, LFSR stimulus, reference rename model and timeout
`timescale 1ns/1ps
`default_nettype none

`include "front_defs.svh"

module tb_front_end import front_pkg::*; ();

  localparam int NUM_PAIRS = 200;
  // Hit delay of up to 2 cycles plus stalls on one cycle in four
  localparam int TIMEOUT_CYCLES = NUM_PAIRS * 24 + 100;
  localparam int MEM_WORDS = 512;
  localparam int BUS_BITS = 1 + `XLEN + 2 * (4 + `XLEN + 3 * `TAG_BITS + 2);
  localparam int JUMP_AT [3] = '{30, 80, 130};
  localparam logic [`XLEN-1:0] JUMP_TO [3] = '{32'h0000_0400, 32'h0000_00F8, 32'h0000_07C0};

  logic                 i_clock;
  logic                 i_reset;
  logic                 o_fetch_read;
  logic [`XLEN-1:0]     o_fetch_address;
  logic                 i_fetch_hit;
  logic [`XLEN-1:0]     i_fetch_instr_0;
  logic [`XLEN-1:0]     i_fetch_instr_1;
  logic                 i_jump_valid;
  logic [`XLEN-1:0]     i_jump_address;
  logic                 i_issue_ready;
  logic                 o_issue_valid;
  logic [`XLEN-1:0]     o_issue_address;
  op_kind_e             o_slot0_op;
  logic [`XLEN-1:0]     o_slot0_imm;
  logic [`TAG_BITS-1:0] o_slot0_dst_tag;
  logic [`TAG_BITS-1:0] o_slot0_src1_tag;
  logic                 o_slot0_src1_pending;
  logic [`TAG_BITS-1:0] o_slot0_src2_tag;
  logic                 o_slot0_src2_pending;
  op_kind_e             o_slot1_op;
  logic [`XLEN-1:0]     o_slot1_imm;
  logic [`TAG_BITS-1:0] o_slot1_dst_tag;
  logic [`TAG_BITS-1:0] o_slot1_src1_tag;
  logic                 o_slot1_src1_pending;
  logic [`TAG_BITS-1:0] o_slot1_src2_tag;
  logic                 o_slot1_src2_pending;

  logic [`XLEN-1:0]     mem [MEM_WORDS];
  logic [15:0]          lfsr_state;
  logic [1:0]           hit_wait = 2'd0;
  int                   issued_seen = 0;
  int                   jump_index = 0;
  int                   fill_index;

  // Reference model state
  logic                 model_pending [`ARCH_REGS];
  logic [`TAG_BITS-1:0] model_tag [`ARCH_REGS];
  logic [`TAG_BITS-1:0] tag_count = '0;
  logic [`XLEN-1:0]     exp_addr = `RESET_PC;
  logic [`XLEN-1:0]     jump_target = '0;
  logic                 jump_pending = 1'b0;
  logic                 old_pair_left = 1'b0;
  logic                 port_held = 1'b0;
  logic [BUS_BITS-1:0]  held_bus = '0;
  logic [BUS_BITS-1:0]  issue_bus;
  logic                 fetch_waiting = 1'b0;
  logic [`XLEN-1:0]     waiting_address = '0;
  int                   pairs_checked = 0;
  int                   run_cycles = 0;

  instr_front_end UUT (.*);

  always #5 i_clock = ~i_clock;

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int n = 0; n < count; n++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  // Registers limited to x0..x7 so pairs depend on each other
  function automatic logic [`XLEN-1:0] random_word();
    logic [`XLEN-1:0] word;
    logic [3:0]       pick;
    word        = take_bits(32);
    pick        = 4'(take_bits(4));
    word[11:7]  = {2'b00, 3'(take_bits(3))};
    word[19:15] = {2'b00, 3'(take_bits(3))};
    word[24:20] = {2'b00, 3'(take_bits(3))};
    case (pick)
      4'd0, 4'd1, 4'd11: word[6:0] = 7'b0110011;
      4'd2, 4'd3: word[6:0] = 7'b0010011;
      4'd4: word[6:0] = 7'b0000011;
      4'd5: word[6:0] = 7'b0100011;
      4'd6: word[6:0] = 7'b1100011;
      4'd7: word[6:0] = 7'b1101111;
      4'd8: word[6:0] = 7'b1100111;
      4'd9: word[6:0] = 7'b0110111;
      4'd10: word[6:0] = 7'b0010111;
      4'd12: word[6:0] = 7'b0001111;
      4'd13: word[6:0] = 7'b1110011;
      default: word[6:0] = word[6:0];
    endcase
    return word;
  endfunction

  function automatic logic [`XLEN-1:0] mem_word(input logic [`XLEN-1:0] address);
    return mem[address[10:2]];
  endfunction

  // Combinational read port with hit timing from the stimulus block
  assign i_fetch_instr_0 = mem_word(o_fetch_address);
  assign i_fetch_instr_1 = mem_word(o_fetch_address + 32'd4);

  assign issue_bus = {o_issue_valid, o_issue_address,
                      o_slot0_op, o_slot0_imm, o_slot0_dst_tag,
                      o_slot0_src1_tag, o_slot0_src1_pending,
                      o_slot0_src2_tag, o_slot0_src2_pending,
                      o_slot1_op, o_slot1_imm, o_slot1_dst_tag,
                      o_slot1_src1_tag, o_slot1_src1_pending,
                      o_slot1_src2_tag, o_slot1_src2_pending};

  // RV32I class by major opcode with unused source fields as x0
  function automatic void ref_decode(
    input  logic [`XLEN-1:0] word,
    output op_kind_e         op,
    output logic [`XLEN-1:0] imm,
    output logic [4:0]       rd,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic             writes
  );
    logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic             use1, use2, dest;
    imm_i = {{20{word[31]}}, word[31:20]};
    imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
    imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    imm_u = {word[31:12], 12'd0};
    imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    use1  = 1'b1;
    use2  = 1'b0;
    dest  = 1'b1;
    imm   = imm_i;
    case (word[6:0])
      7'b0010011: op = OP_ALU_IMM;
      7'b0000011: op = OP_LOAD;
      7'b1100111: op = OP_JALR;
      7'b0110011: begin
        op   = OP_ALU_REG;
        use2 = 1'b1;
        imm  = '0;
      end
      7'b0100011, 7'b1100011: begin
        op   = (word[6:0] == 7'b0100011) ? OP_STORE : OP_BRANCH;
        imm  = (word[6:0] == 7'b0100011) ? imm_s : imm_b;
        use2 = 1'b1;
        dest = 1'b0;
      end
      7'b1101111, 7'b0110111, 7'b0010111: begin
        op   = (word[6:0] == 7'b1101111) ? OP_JAL :
               (word[6:0] == 7'b0110111) ? OP_LUI : OP_AUIPC;
        imm  = (word[6:0] == 7'b1101111) ? imm_j : imm_u;
        use1 = 1'b0;
      end
      default: begin
        op   = OP_INVALID;
        imm  = '0;
        use1 = 1'b0;
        dest = 1'b0;
      end
    endcase
    writes = dest && (word[11:7] != 5'd0);
    rd     = word[11:7];
    rs1    = use1 ? word[19:15] : 5'd0;
    rs2    = use2 ? word[24:20] : 5'd0;
  endfunction

  function automatic logic is_pending(input logic [4:0] register);
    return (register != 5'd0) && model_pending[register];
  endfunction

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_op(input string name, input op_kind_e got, input op_kind_e exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_data(input string name, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_tag(input string name, input logic [`TAG_BITS-1:0] got,
                           input logic [`TAG_BITS-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // Rename one transferred pair in the model and compare every field
  task automatic check_pair();
    logic [`XLEN-1:0]     w0, w1, imm0, imm1;
    op_kind_e             op0, op1;
    logic [4:0]           rd0, a0, b0, rd1, a1, b1;
    logic                 wr0, wr1, pa0, pb0, pa1, pb1;
    logic [`TAG_BITS-1:0] ta0, tb0, ta1, tb1, dst0, dst1;
    if (old_pair_left) begin
      old_pair_left = 1'b0;
    end else if (jump_pending) begin
      exp_addr     = jump_target;
      jump_pending = 1'b0;
    end
    check_data("o_issue_address", o_issue_address, exp_addr);
    w0 = mem_word(exp_addr);
    w1 = mem_word(exp_addr + 32'd4);
    ref_decode(w0, op0, imm0, rd0, a0, b0, wr0);
    ref_decode(w1, op1, imm1, rd1, a1, b1, wr1);
    pa0 = is_pending(a0);
    ta0 = model_tag[a0];
    pb0 = is_pending(b0);
    tb0 = model_tag[b0];
    pa1 = is_pending(a1);
    ta1 = model_tag[a1];
    pb1 = is_pending(b1);
    tb1 = model_tag[b1];
    // Slot 1 reads slot 0's new tag
    if (wr0 && (a1 == rd0)) begin
      pa1 = 1'b1;
      ta1 = tag_count;
    end
    if (wr0 && (b1 == rd0)) begin
      pb1 = 1'b1;
      tb1 = tag_count;
    end
    dst0 = tag_count;
    if (wr0) tag_count = tag_count + `TAG_BITS'(1);
    dst1 = tag_count;
    if (wr1) tag_count = tag_count + `TAG_BITS'(1);
    if (wr0) begin
      model_pending[rd0] = 1'b1;
      model_tag[rd0]     = dst0;
    end
    if (wr1) begin
      model_pending[rd1] = 1'b1;
      model_tag[rd1]     = dst1;
    end
    check_op("o_slot0_op", o_slot0_op, op0);
    check_data("o_slot0_imm", o_slot0_imm, imm0);
    if (wr0) check_tag("o_slot0_dst_tag", o_slot0_dst_tag, dst0);
    check_flag("o_slot0_src1_pending", o_slot0_src1_pending, pa0);
    if (pa0) check_tag("o_slot0_src1_tag", o_slot0_src1_tag, ta0);
    check_flag("o_slot0_src2_pending", o_slot0_src2_pending, pb0);
    if (pb0) check_tag("o_slot0_src2_tag", o_slot0_src2_tag, tb0);
    check_op("o_slot1_op", o_slot1_op, op1);
    check_data("o_slot1_imm", o_slot1_imm, imm1);
    if (wr1) check_tag("o_slot1_dst_tag", o_slot1_dst_tag, dst1);
    check_flag("o_slot1_src1_pending", o_slot1_src1_pending, pa1);
    if (pa1) check_tag("o_slot1_src1_tag", o_slot1_src1_tag, ta1);
    check_flag("o_slot1_src2_pending", o_slot1_src2_pending, pb1);
    if (pb1) check_tag("o_slot1_src2_tag", o_slot1_src2_tag, tb1);
    exp_addr      = exp_addr + 32'd8;
    pairs_checked = pairs_checked + 1;
  endtask

  initial begin
    i_clock        = 1'b0;
    i_reset        = 1'b1;
    i_fetch_hit    = 1'b0;
    i_jump_valid   = 1'b0;
    i_jump_address = '0;
    i_issue_ready  = 1'b0;
    lfsr_state     = 16'd6651;
    for (fill_index = 0; fill_index < MEM_WORDS; fill_index++) begin
      mem[fill_index] = random_word();
    end
    for (fill_index = 0; fill_index < `ARCH_REGS; fill_index++) begin
      model_pending[fill_index] = 1'b0;
    end
    repeat (5) @(posedge i_clock);
    i_reset <= 1'b0;
  end

  // Hit timing, back-pressure and jumps at fixed pair counts
  always @(posedge i_clock) begin
    if (o_issue_valid && i_issue_ready) begin
      issued_seen = issued_seen + 1;
    end
    if (o_fetch_read && i_fetch_hit) begin
      hit_wait = 2'(take_bits(2) % 3);
    end else if (hit_wait != 2'd0) begin
      hit_wait = hit_wait - 2'd1;
    end
    i_fetch_hit   <= (hit_wait == 2'd0);
    i_issue_ready <= (take_bits(2) != 32'd0);
    if (!i_reset && jump_index < 3 && issued_seen == JUMP_AT[jump_index]) begin
      i_jump_valid   <= 1'b1;
      i_jump_address <= JUMP_TO[jump_index];
      jump_index = jump_index + 1;
    end else begin
      i_jump_valid <= 1'b0;
    end
  end

  always @(posedge i_clock) begin
    if (i_reset) begin
      run_cycles = 0;
    end else begin
      if (run_cycles == 0 && (o_issue_valid || o_fetch_read)) begin
        $display("Fetch or issue was active in the first cycle after reset");
        stop_run();
      end
      run_cycles = run_cycles + 1;
      if (run_cycles > TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles with %0d of %0d pairs checked",
                 run_cycles, pairs_checked, NUM_PAIRS);
        stop_run();
      end
      if (port_held && issue_bus !== held_bus) begin
        $display("[ERROR] issue_bus got 0x%h expected 0x%h", issue_bus, held_bus);
        stop_run();
      end
      port_held = o_issue_valid && !i_issue_ready;
      held_bus  = issue_bus;
      // A read without a hit keeps its address
      if (fetch_waiting && o_fetch_read && o_fetch_address !== waiting_address) begin
        $display("[ERROR] o_fetch_address got 0x%h expected 0x%h",
                 o_fetch_address, waiting_address);
        stop_run();
      end
      fetch_waiting   = o_fetch_read && !i_fetch_hit;
      waiting_address = o_fetch_address;
      // Only the pair already at the port may still carry an old address
      if (i_jump_valid) begin
        jump_pending  = 1'b1;
        old_pair_left = o_issue_valid;
        jump_target   = i_jump_address;
      end
      if (o_issue_valid && i_issue_ready) begin
        check_pair();
      end
      if (pairs_checked == NUM_PAIRS) begin
        $display("Result: PASSED");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+rtl
rtl/front_pkg.sv
rtl/fetch_loader.sv
rtl/instr_decoder.sv
rtl/reg_renamer.sv
rtl/front_control.sv
rtl/instr_front_end.sv
test/front_end_props.sv
test/tb_front_end.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_front_end -Mdir obj_dir -f compile.f

output=$(./obj_dir/Vtb_front_end 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
